//--- compile.f
verilog/narrator_pkg.sv
verilog/key_repeat.sv
verilog/speed_control.sv
verilog/sample_reader.sv
verilog/volume_meter.sv
verilog/talking_narrator.sv
verification/tb_talking_narrator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the talking_narrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f compile.f \
  --top-module tb_talking_narrator -Mdir "$BUILD_DIR" -o tb_talking_narrator
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_talking_narrator" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
exit 1

//--- verification/tb_talking_narrator.sv
`timescale 1ns/1ps

module tb_talking_narrator
  import narrator_pkg::*;
();

  localparam int       REPEAT_CYCLES = 40;
  localparam divisor_t DEF_DIVISOR   = 16'd32;
  localparam int       STEP          = 4;
  localparam divisor_t MIN_DIV       = 16'd24;
  localparam divisor_t MAX_DIV       = 16'd48;
  localparam int       MEM_WORDS     = 512;
  localparam int       KEY_UP        = 0;
  localparam int       KEY_DOWN      = 1;
  localparam int       KEY_RESTORE   = 2;
  localparam logic [31:0] SEED       = 32'hd3c1;

  // About 7000 cycles of tests, the rest is room for fetch stalls
  localparam int TIMEOUT_CYCLES = 20000;

  logic          CLK_50M;
  logic          rst;
  logic [2:0]    key;
  phoneme_t      phoneme;
  logic          start;
  flash_rsp_t    flash_rsp;
  flash_req_t    flash_req;
  audio_sample_t sample;
  logic          sample_valid;
  logic          busy;
  logic          finish;
  led_bar_t      led;
  divisor_t      divisor;

  flash_word_t mem [0:MEM_WORDS-1];
  logic [31:0] rand_state;
  int          cycle_count = 0;
  int          sample_errors = 0;
  int          led_errors = 0;
  int          divisor_errors = 0;
  int          other_errors = 0;

  talking_narrator #(
    .REPEAT_CYCLES   (REPEAT_CYCLES),
    .DEFAULT_DIVISOR (DEF_DIVISOR),
    .SPEED_STEP      (divisor_t'(STEP)),
    .MIN_DIVISOR     (MIN_DIV),
    .MAX_DIVISOR     (MAX_DIV)
  ) talking_narrator_i (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .key          (key),
    .phoneme      (phoneme),
    .start        (start),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid),
    .busy         (busy),
    .finish       (finish),
    .led          (led),
    .divisor      (divisor)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    lcg_next = x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Byte n of phoneme p, low byte of each word first
  function automatic audio_sample_t expected_sample(input phoneme_t p, input int n);
    int          w;
    flash_word_t word;
    w = int'(p) * PHONEME_SLOT_WORDS + n / SAMPLES_PER_WORD;
    word = mem[9'(w)];
    expected_sample = audio_sample_t'(word >> (8 * (n % SAMPLES_PER_WORD)));
  endfunction

  // One LED per 16 of magnitude, at most 8
  function automatic led_bar_t bar_for(input audio_sample_t s);
    int mag;
    int lit;
    mag = (s < 0) ? -int'(s) : int'(s);
    lit = mag / 16;
    if (lit > 8)
      lit = 8;
    bar_for = '0;
    for (int i = 0; i < lit; i++)
      bar_for[i] = 1'b1;
  endfunction

  task automatic check_sample(input audio_sample_t got, input audio_sample_t want);
    if (got !== want)
    begin
      sample_errors++;
      $display("[FAIL] sample: got %h expected %h at %0t", got, want, $time);
    end
  endtask

  task automatic check_led(input led_bar_t got, input led_bar_t want);
    if (got !== want)
    begin
      led_errors++;
      $display("[FAIL] led: got %h expected %h at %0t", got, want, $time);
    end
  endtask

  task automatic check_divisor(input divisor_t got, input divisor_t want);
    if (got !== want)
    begin
      divisor_errors++;
      $display("[FAIL] divisor: got %h expected %h at %0t", got, want, $time);
    end
  endtask

  task automatic flag_error(input string msg);
    other_errors++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  // ==================================================
  // Clock, watchdog, flash model
  // ==================================================

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  // Random stall before accept, then data 1 to 4 cycles later
  initial
  begin : flash_model
    int          stall_left;
    int          delay_left;
    logic        req_open;
    logic        pending;
    flash_addr_t pend_addr;
    for (int w = 0; w < MEM_WORDS; w++)
      mem[w] = lcg_next(lcg_next(SEED ^ 32'(w)));
    rand_state = SEED;
    stall_left = 0;
    delay_left = 0;
    req_open   = 1'b0;
    pending    = 1'b0;
    pend_addr  = '0;
    flash_rsp  = '{waitrequest: 1'b1, readdatavalid: 1'b0, readdata: '0};
    forever
    begin
      @(negedge CLK_50M);
      flash_rsp.readdatavalid = 1'b0;
      flash_rsp.waitrequest   = 1'b1;
      if (pending)
      begin
        if (delay_left == 0)
        begin
          flash_rsp.readdatavalid = 1'b1;
          flash_rsp.readdata      = mem[pend_addr[8:0]];
          pending = 1'b0;
        end
        else
          delay_left--;
      end
      else if (flash_req.read)
      begin
        if (!req_open)
        begin
          req_open   = 1'b1;
          rand_state = lcg_next(rand_state);
          stall_left = int'(rand_state[17:16]);
        end
        if (stall_left > 0)
          stall_left--;
        else
        begin
          // Accepted at the coming rising edge
          flash_rsp.waitrequest = 1'b0;
          req_open   = 1'b0;
          pending    = 1'b1;
          pend_addr  = flash_req.address;
          rand_state = lcg_next(rand_state);
          delay_left = int'(rand_state[17:16]);
        end
      end
    end
  end

  // ==================================================
  // Tests
  // ==================================================

  task automatic check_reset_state();
    if (flash_req.read !== 1'b0 || sample_valid !== 1'b0 || finish !== 1'b0 || busy !== 1'b0)
      flag_error("control outputs not low after reset");
    if (talking_narrator_i.speed_events !== 3'b000)
      flag_error("speed event pulse high after reset");
    check_led(led, '0);
    check_divisor(divisor, DEF_DIVISOR);
  endtask

  task automatic play_phoneme(input phoneme_t p);
    int            total;
    int            n;
    int            prev_cyc;
    divisor_t      div_now;
    audio_sample_t want;
    audio_sample_t last_want;
    logic          led_due;
    logic          done;
    logic          silent;
    silent    = (p == SILENCE_PHONEME);
    total     = silent ? SILENT_SAMPLES
                       : ((p % 4) + 1) * PHONEME_UNIT_WORDS * SAMPLES_PER_WORD;
    n         = 0;
    prev_cyc  = -1;
    led_due   = 1'b0;
    done      = 1'b0;
    last_want = '0;
    while (busy)
      @(negedge CLK_50M);
    div_now = divisor;
    phoneme = p;
    start   = 1'b1;
    @(negedge CLK_50M);
    start = 1'b0;
    if (!busy)
      flag_error($sformatf("busy did not rise after start of phoneme %0d", p));
    while (!done)
    begin
      @(negedge CLK_50M);
      start = 1'b0;
      if (led_due)
      begin
        check_led(led, bar_for(last_want));
        led_due = 1'b0;
      end
      if (silent && flash_req.read)
        flag_error("flash read during silence");
      if (finish)
      begin
        done = 1'b1;
        if (n != total)
          flag_error($sformatf("phoneme %0d gave %0d samples, not %0d", p, n, total));
        if (busy)
          flag_error("busy still high with finish");
      end
      else if (!busy)
      begin
        done = 1'b1;
        flag_error($sformatf("busy fell before finish of phoneme %0d", p));
      end
      if (sample_valid)
      begin
        want = silent ? audio_sample_t'(0) : expected_sample(p, n);
        check_sample(sample, want);
        if (prev_cyc >= 0 && cycle_count - prev_cyc != int'(div_now))
          flag_error($sformatf("sample gap %0d cycles, divisor is %0d",
                               cycle_count - prev_cyc, div_now));
        prev_cyc  = cycle_count;
        last_want = want;
        led_due   = 1'b1;
        n++;
        // Stray start in mid playback, must be ignored
        if (n == 2)
        begin
          phoneme = p + 8'd1;
          start   = 1'b1;
        end
      end
    end
    repeat (int'(div_now) + 4)
    begin
      @(negedge CLK_50M);
      if (finish || sample_valid || busy)
        flag_error($sformatf("activity after finish of phoneme %0d", p));
    end
  endtask

  // Hold one speed key and follow each divisor step
  task automatic hold_speed_key(input int idx, input int step, input divisor_t settle,
                                input int hold_cycles);
    divisor_t prev;
    int       want;
    int       last_change;
    prev        = divisor;
    last_change = -1;
    key[idx]    = 1'b0;
    repeat (hold_cycles)
    begin
      @(negedge CLK_50M);
      if (divisor !== prev)
      begin
        want = int'(prev) + step;
        if (want < int'(MIN_DIV))
          want = int'(MIN_DIV);
        if (want > int'(MAX_DIV))
          want = int'(MAX_DIV);
        check_divisor(divisor, divisor_t'(want));
        if (last_change >= 0 && cycle_count - last_change != REPEAT_CYCLES)
          flag_error($sformatf("key repeat gap %0d cycles", cycle_count - last_change));
        last_change = cycle_count;
        prev        = divisor;
      end
    end
    key[idx] = 1'b1;
    repeat (4) @(negedge CLK_50M);
    check_divisor(divisor, settle);
  endtask

  task automatic press_restore();
    key[KEY_RESTORE] = 1'b0;
    repeat (6) @(negedge CLK_50M);
    key[KEY_RESTORE] = 1'b1;
    repeat (4) @(negedge CLK_50M);
    check_divisor(divisor, DEF_DIVISOR);
  endtask

  initial
  begin
    rst     = 1'b1;
    key     = 3'b111;
    phoneme = '0;
    start   = 1'b0;
    repeat (4) @(negedge CLK_50M);
    rst = 1'b0;
    check_reset_state();

    play_phoneme(8'd1);
    play_phoneme(8'd2);
    play_phoneme(8'd7);
    play_phoneme(SILENCE_PHONEME);

    hold_speed_key(KEY_UP, -STEP, MIN_DIV, 4 * REPEAT_CYCLES);
    // Spacing again at the fastest rate
    play_phoneme(8'd5);
    hold_speed_key(KEY_DOWN, STEP, MAX_DIV, 8 * REPEAT_CYCLES);
    press_restore();

    $display("Errors: %0d total, %0d sample, %0d led, %0d divisor, %0d other",
             sample_errors + led_errors + divisor_errors + other_errors,
             sample_errors, led_errors, divisor_errors, other_errors);
    if (sample_errors + led_errors + divisor_errors + other_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- verilog/talking_narrator.sv
`timescale 1ns/1ps

module talking_narrator
  import narrator_pkg::*;
#(
  parameter int       REPEAT_CYCLES   = 40,
  parameter divisor_t DEFAULT_DIVISOR = 16'd32,
  parameter divisor_t SPEED_STEP      = 16'd4,
  parameter divisor_t MIN_DIVISOR     = 16'd24,
  parameter divisor_t MAX_DIVISOR     = 16'd48
)
(
  input  logic          CLK_50M,
  input  logic          rst,
  // Active low, 0 up, 1 down, 2 restore
  input  logic [2:0]    key,
  input  phoneme_t      phoneme,
  input  logic          start,
  input  flash_rsp_t    flash_rsp,
  output flash_req_t    flash_req,
  output audio_sample_t sample,
  output logic          sample_valid,
  output logic          busy,
  output logic          finish,
  output led_bar_t      led,
  output divisor_t      divisor
);

  speed_events_t speed_events;
  logic          sample_strobe;

  // ==================================================
  // Speed path
  // ==================================================

  key_repeat #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) key_repeat_i (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .key     (key),
    .events  (speed_events)
  );

  speed_control #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR),
    .SPEED_STEP      (SPEED_STEP),
    .MIN_DIVISOR     (MIN_DIVISOR),
    .MAX_DIVISOR     (MAX_DIVISOR)
  ) speed_control_i (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .events        (speed_events),
    .divisor       (divisor),
    .sample_strobe (sample_strobe)
  );

  // ==================================================
  // Playback path
  // ==================================================

  sample_reader sample_reader_i (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .phoneme       (phoneme),
    .start         (start),
    .sample_strobe (sample_strobe),
    .flash_req     (flash_req),
    .flash_rsp     (flash_rsp),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .busy          (busy),
    .finish        (finish)
  );

  volume_meter volume_meter_i (
    .CLK_50M      (CLK_50M),
    .rst          (rst),
    .sample       (sample),
    .sample_valid (sample_valid),
    .led          (led)
  );

endmodule

//--- verilog/volume_meter.sv
`timescale 1ns/1ps

module volume_meter
  import narrator_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  audio_sample_t sample,
  input  logic          sample_valid,
  output led_bar_t      led
);

  logic [7:0] magnitude;
  logic [3:0] level;
  logic [8:0] bar_full;
  led_bar_t   bar;

  // ==================================================
  // Magnitude to bar
  // ==================================================

  // -128 comes out as 8'h80, read unsigned as 128
  always_comb
  begin
    if (sample[7])
      magnitude = 8'(-sample);
    else
      magnitude = 8'(sample);
  end

  // One LED per 16 steps of magnitude, 0 to 8
  assign level = magnitude[7:4];

  // Thermometer fill from bit 0 upward
  assign bar_full = (9'd1 << level) - 9'd1;
  assign bar      = bar_full[7:0];

  // Bar holds between samples
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      led <= '0;
    else if (sample_valid)
      led <= bar;
  end

endmodule

//--- verilog/sample_reader.sv
`timescale 1ns/1ps

module sample_reader
  import narrator_pkg::*;
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  phoneme_t      phoneme,
  input  logic          start,
  input  logic          sample_strobe,
  output flash_req_t    flash_req,
  input  flash_rsp_t    flash_rsp,
  output audio_sample_t sample,
  output logic          sample_valid,
  output logic          busy,
  output logic          finish
);

  localparam int COUNT_W  = $clog2(4 * PHONEME_UNIT_WORDS + 1);
  localparam int SILENT_W = $clog2(SILENT_SAMPLES + 1);
  localparam int BYTE_W   = $clog2(SAMPLES_PER_WORD);
  localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(SAMPLES_PER_WORD - 1);

  reader_state_t state;

  // Memory side
  logic                req_read;
  flash_addr_t         req_address;
  flash_addr_t         fetch_addr;
  logic [COUNT_W-1:0]  fetch_left;

  // Word being played and one prefetched behind it
  flash_word_t         cur_word;
  logic                cur_valid;
  flash_word_t         next_word;
  logic                next_valid;
  logic [BYTE_W-1:0]   byte_idx;

  logic [SILENT_W-1:0] silent_left;
  logic                last_sent;

  flash_addr_t         start_addr;
  logic [COUNT_W-1:0]  word_count;

  logic accept_start;
  logic fetch_accept;
  logic data_arrive;
  logic playing;
  logic emit_word;
  logic emit_silent;
  logic word_done;
  logic promote;
  logic prefetch;
  logic last_word_sample;
  logic last_silent;

  // Phoneme p starts at p*64 and spans ((p mod 4)+1)*4 words
  assign start_addr = flash_addr_t'(phoneme) * flash_addr_t'(PHONEME_SLOT_WORDS);
  assign word_count = COUNT_W'((phoneme % 4 + 1) * PHONEME_UNIT_WORDS);

  assign flash_req = '{read: req_read, address: req_address};
  assign busy      = (state != idle);

  // ==================================================
  // Event decode
  // ==================================================

  assign accept_start = start && (state == idle);
  assign fetch_accept = req_read && !flash_rsp.waitrequest;
  assign data_arrive  = (state == wait_data) && flash_rsp.readdatavalid;
  assign playing      = (state == fetch) || (state == wait_data) || (state == play);
  assign emit_word    = sample_strobe && playing && cur_valid;
  assign emit_silent  = sample_strobe && (state == silence) && (silent_left != '0);
  assign word_done    = emit_word && (byte_idx == LAST_BYTE);
  assign promote      = next_valid && (!cur_valid || word_done);

  // Next word goes out once the current one has given its first byte
  assign prefetch = (state == play) && (fetch_left != '0) && !next_valid
                    && cur_valid && (byte_idx != '0);

  assign last_word_sample = word_done && (state == play) && (fetch_left == '0) && !next_valid;
  assign last_silent      = emit_silent && (silent_left == SILENT_W'(1));

  // ==================================================
  // Control FSM
  // ==================================================

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state        <= idle;
      req_read     <= 1'b0;
      fetch_left   <= '0;
      silent_left  <= '0;
      cur_valid    <= 1'b0;
      next_valid   <= 1'b0;
      byte_idx     <= '0;
      sample_valid <= 1'b0;
      last_sent    <= 1'b0;
      finish       <= 1'b0;
    end
    else
    begin
      sample_valid <= emit_word || emit_silent;
      last_sent    <= last_word_sample || last_silent;
      finish       <= last_sent;

      if (emit_word)
        byte_idx <= byte_idx + 1'b1;
      if (promote)
        cur_valid <= 1'b1;
      else if (word_done)
        cur_valid <= 1'b0;
      if (data_arrive)
        next_valid <= 1'b1;
      else if (promote)
        next_valid <= 1'b0;
      if (emit_silent)
        silent_left <= silent_left - 1'b1;

      case (state)
        idle:
          if (accept_start)
          begin
            cur_valid  <= 1'b0;
            next_valid <= 1'b0;
            byte_idx   <= '0;
            if (phoneme == SILENCE_PHONEME)
            begin
              silent_left <= SILENT_W'(SILENT_SAMPLES);
              state       <= silence;
            end
            else
            begin
              req_read   <= 1'b1;
              fetch_left <= word_count - 1'b1;
              state      <= fetch;
            end
          end
        fetch:
          if (fetch_accept)
          begin
            req_read <= 1'b0;
            state    <= wait_data;
          end
        wait_data:
          if (data_arrive)
            state <= play;
        play:
          if (last_sent)
            state <= idle;
          else if (prefetch)
          begin
            req_read   <= 1'b1;
            fetch_left <= fetch_left - 1'b1;
            state      <= fetch;
          end
        silence:
          if (last_sent)
            state <= idle;
        default:
          state <= idle;
      endcase
    end
  end

  // Address, word buffers and sample output
  always_ff @(posedge CLK_50M)
  begin
    if (accept_start)
    begin
      req_address <= start_addr;
      fetch_addr  <= start_addr + 1'b1;
    end
    else if (prefetch)
    begin
      req_address <= fetch_addr;
      fetch_addr  <= fetch_addr + 1'b1;
    end

    if (data_arrive)
      next_word <= flash_rsp.readdata;
    if (promote)
      cur_word <= next_word;

    // Low byte of each word plays first
    if (emit_word)
      sample <= audio_sample_t'(cur_word[8*byte_idx +: 8]);
    else if (emit_silent)
      sample <= '0;
  end

  assert property (@(posedge CLK_50M) disable iff (rst)
    (flash_req.read && flash_rsp.waitrequest)
      |=> (flash_req.read && $stable(flash_req.address)))
    else $error("flash request moved while stalled");

endmodule

//--- verilog/speed_control.sv
`timescale 1ns/1ps

module speed_control
  import narrator_pkg::*;
#(
  parameter divisor_t DEFAULT_DIVISOR = 16'd32,
  parameter divisor_t SPEED_STEP      = 16'd4,
  parameter divisor_t MIN_DIVISOR     = 16'd24,
  parameter divisor_t MAX_DIVISOR     = 16'd48
)
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  speed_events_t events,
  output divisor_t      divisor,
  output logic          sample_strobe
);

  divisor_t strobe_count;
  divisor_t divisor_faster;
  divisor_t divisor_slower;

  // ==================================================
  // Divisor register
  // ==================================================

  // Next values for each step direction, clamped
  always_comb
  begin
    if (divisor < MIN_DIVISOR + SPEED_STEP)
      divisor_faster = MIN_DIVISOR;
    else
      divisor_faster = divisor - SPEED_STEP;

    if (divisor > MAX_DIVISOR - SPEED_STEP)
      divisor_slower = MAX_DIVISOR;
    else
      divisor_slower = divisor + SPEED_STEP;
  end

  // Restore first, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      divisor <= DEFAULT_DIVISOR;
    else if (events.restore)
      divisor <= DEFAULT_DIVISOR;
    else if (events.up)
      divisor <= divisor_faster;
    else if (events.down)
      divisor <= divisor_slower;
  end

  // ==================================================
  // Sample rate strobe
  // ==================================================

  // One strobe per divisor cycles
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      strobe_count  <= '0;
      sample_strobe <= 1'b0;
    end
    else if (strobe_count >= divisor - 1'b1)
    begin
      strobe_count  <= '0;
      sample_strobe <= 1'b1;
    end
    else
    begin
      strobe_count  <= strobe_count + 1'b1;
      sample_strobe <= 1'b0;
    end
  end

  assert property (@(posedge CLK_50M) disable iff (rst)
    (divisor >= MIN_DIVISOR) && (divisor <= MAX_DIVISOR))
    else $error("divisor left its allowed range");

endmodule

//--- verilog/key_repeat.sv
`timescale 1ns/1ps

module key_repeat
  import narrator_pkg::*;
#(
  parameter int REPEAT_CYCLES = 40
)
(
  input  logic          CLK_50M,
  input  logic          rst,
  input  logic [2:0]    key,
  output speed_events_t events
);

  localparam int COUNT_W = $clog2(REPEAT_CYCLES + 1);
  localparam logic [COUNT_W-1:0] COUNT_LAST = COUNT_W'(REPEAT_CYCLES - 1);

  // Key bits: 0 up, 1 down, 2 restore
  logic [2:0]         key_meta;
  logic [2:0]         key_sync;
  logic [2:0]         held;
  logic               restore_prev;
  logic [COUNT_W-1:0] repeat_count;
  logic               repeat_held;
  logic               repeat_tick;

  // Two flop synchronizer, released keys read high
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      key_meta <= 3'b111;
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  assign held        = ~key_sync;
  // Up and down held together cancel out
  assign repeat_held = held[0] ^ held[1];
  assign repeat_tick = repeat_held && (repeat_count == COUNT_LAST);

  // Shared interval counter, restarts on every new press
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      repeat_count <= '0;
    else if (!repeat_held || repeat_tick)
      repeat_count <= '0;
    else
      repeat_count <= repeat_count + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      events       <= '0;
      restore_prev <= 1'b0;
    end
    else
    begin
      restore_prev   <= held[2];
      events.up      <= repeat_tick && held[0];
      events.down    <= repeat_tick && held[1];
      events.restore <= held[2] && !restore_prev;
    end
  end

  assert property (@(posedge CLK_50M) disable iff (rst) !(events.up && events.down))
    else $error("speed up and speed down pulsed together");

endmodule

//--- verilog/narrator_pkg.sv
package narrator_pkg;

  // ==================================================
  // Widths with a meaning
  // ==================================================

  typedef logic signed [7:0] audio_sample_t;
  typedef logic [31:0]       flash_word_t;
  typedef logic [22:0]       flash_addr_t;
  typedef logic [7:0]        phoneme_t;
  typedef logic [15:0]       divisor_t;
  typedef logic [7:0]        led_bar_t;

  // ==================================================
  // Memory port and control bundles
  // ==================================================

  // Read request toward the flash
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Flash response, data lags the accepted request
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // One-cycle pulses from the speed keys
  typedef struct packed {
    logic up;
    logic down;
    logic restore;
  } speed_events_t;

  typedef enum logic [2:0] {
    idle,
    fetch,
    wait_data,
    play,
    silence
  } reader_state_t;

  // ==================================================
  // Phoneme layout in flash
  // ==================================================

  localparam int PHONEME_SLOT_WORDS = 64;
  localparam int PHONEME_UNIT_WORDS = 4;
  localparam int SILENT_SAMPLES     = 16;
  localparam int SAMPLES_PER_WORD   = 4;

  // Phoneme number reserved for a pause
  localparam phoneme_t SILENCE_PHONEME = 8'd0;

endpackage
